// ==== Bender.yml ====
package:
  name: acs_matrix

sources:
  - rtl/viterbi_pkg.sv
  - rtl/acs_unit.sv
  - rtl/acs_column.sv
  - rtl/acs_matrix.sv
  - target: simulation
    files:
      - sim/acs_matrix_asserts.sv
      - sim/tb_acs_matrix.sv

// ==== filelist.f ====
rtl/viterbi_pkg.sv
rtl/acs_unit.sv
rtl/acs_column.sv
rtl/acs_matrix.sv
sim/acs_matrix_asserts.sv
sim/tb_acs_matrix.sv

// ==== rtl/acs_column.sv ====
`timescale 1ns/100ps

module acs_column #(
	parameter int STAGE = 0
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     advance,

	input  logic                     in_valid,
	input  viterbi_pkg::id_t         in_id,
	input  viterbi_pkg::sym_block_t  in_syms,
	input  viterbi_pkg::pm_vec_t     in_pm,
	input  viterbi_pkg::flag_vec_t   in_unreach,
	input  viterbi_pkg::dec_matrix_t in_dec,

	output logic                     out_valid,
	output viterbi_pkg::id_t         out_id,
	output viterbi_pkg::sym_block_t  out_syms,
	output viterbi_pkg::pm_vec_t     out_pm,
	output viterbi_pkg::flag_vec_t   out_unreach,
	output viterbi_pkg::dec_matrix_t out_dec
);

	viterbi_pkg::sym_t        col_sym;
	viterbi_pkg::pm_vec_t     col_pm;
	viterbi_pkg::flag_vec_t   col_unreach;
	viterbi_pkg::flag_vec_t   col_dec;
	viterbi_pkg::dec_matrix_t dec_next;

	// this column's symbol out of the travelling block
	assign col_sym = in_syms[STAGE];

	// one ACS per destination state
	for (genvar s = 0; s < viterbi_pkg::NUM_STATES; s++) begin : g_acs
		localparam int P0 = 2 * (s % 2);
		localparam int P1 = P0 + 1;

		acs_unit #(
			.DEST_STATE (viterbi_pkg::state_t'(s))
		) u_acs_unit (
			.in_sym      (col_sym),
			.pm_p0       (in_pm[P0]),
			.pm_p1       (in_pm[P1]),
			.unreach_p0  (in_unreach[P0]),
			.unreach_p1  (in_unreach[P1]),
			.pm_out      (col_pm[s]),
			.unreach_out (col_unreach[s]),
			.dec_out     (col_dec[s])
		);
	end

	// earlier rows pass through, this column fills its own row
	always_comb begin
		dec_next        = in_dec;
		dec_next[STAGE] = col_dec;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (advance) begin
			out_valid <= in_valid;
		end
	end

	// block payload moves with its valid bit
	always_ff @(posedge clk) begin
		if (advance) begin
			out_id      <= in_id;
			out_syms    <= in_syms;
			out_pm      <= col_pm;
			out_unreach <= col_unreach;
			out_dec     <= dec_next;
		end
	end

endmodule

// ==== rtl/acs_matrix.sv ====
`timescale 1ns/100ps

module acs_matrix (
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic                     in_valid,
	output logic                     in_ready,
	input  viterbi_pkg::id_t         in_id,
	input  viterbi_pkg::sym_block_t  in_syms,

	output logic                     out_valid,
	input  logic                     out_ready,
	output viterbi_pkg::id_t         out_id,
	output viterbi_pkg::pm_vec_t     out_pm,
	output viterbi_pkg::dec_matrix_t out_dec
);

	// index k is the input of column k, index NUM_STAGES the last register
	logic                     stage_valid   [0:viterbi_pkg::NUM_STAGES];
	viterbi_pkg::id_t         stage_id      [0:viterbi_pkg::NUM_STAGES];
	viterbi_pkg::sym_block_t  stage_syms    [0:viterbi_pkg::NUM_STAGES];
	viterbi_pkg::pm_vec_t     stage_pm      [0:viterbi_pkg::NUM_STAGES];
	viterbi_pkg::flag_vec_t   stage_unreach [0:viterbi_pkg::NUM_STAGES];
	viterbi_pkg::dec_matrix_t stage_dec     [0:viterbi_pkg::NUM_STAGES];

	logic advance;

	// whole pipeline moves together or freezes together
	assign advance  = !stage_valid[viterbi_pkg::NUM_STAGES] || out_ready;
	assign in_ready = advance;

	// column 0 starts every block from the known start state
	assign stage_valid[0]   = in_valid;
	assign stage_id[0]      = in_id;
	assign stage_syms[0]    = in_syms;
	assign stage_pm[0]      = viterbi_pkg::PM_INIT;
	assign stage_unreach[0] = viterbi_pkg::UNREACH_INIT;
	assign stage_dec[0]     = '0;

	for (genvar k = 0; k < viterbi_pkg::NUM_STAGES; k++) begin : g_col
		acs_column #(
			.STAGE (k)
		) u_acs_column (
			.clk         (clk),
			.rst_n       (rst_n),
			.advance     (advance),
			.in_valid    (stage_valid[k]),
			.in_id       (stage_id[k]),
			.in_syms     (stage_syms[k]),
			.in_pm       (stage_pm[k]),
			.in_unreach  (stage_unreach[k]),
			.in_dec      (stage_dec[k]),
			.out_valid   (stage_valid[k+1]),
			.out_id      (stage_id[k+1]),
			.out_syms    (stage_syms[k+1]),
			.out_pm      (stage_pm[k+1]),
			.out_unreach (stage_unreach[k+1]),
			.out_dec     (stage_dec[k+1])
		);
	end

	// results straight from the last column register
	assign out_valid = stage_valid[viterbi_pkg::NUM_STAGES];
	assign out_id    = stage_id[viterbi_pkg::NUM_STAGES];
	assign out_pm    = stage_pm[viterbi_pkg::NUM_STAGES];
	assign out_dec   = stage_dec[viterbi_pkg::NUM_STAGES];

endmodule

// ==== rtl/acs_unit.sv ====
`timescale 1ns/100ps

module acs_unit #(
	parameter viterbi_pkg::state_t DEST_STATE = 2'd0
) (
	input  viterbi_pkg::sym_t in_sym,
	input  viterbi_pkg::pm_t  pm_p0,
	input  viterbi_pkg::pm_t  pm_p1,
	input  logic              unreach_p0,
	input  logic              unreach_p1,
	output viterbi_pkg::pm_t  pm_out,
	output logic              unreach_out,
	output logic              dec_out
);

	// predecessors share the older bit of the destination
	localparam viterbi_pkg::state_t PRED_0 = {DEST_STATE[0], 1'b0};
	localparam viterbi_pkg::state_t PRED_1 = {DEST_STATE[0], 1'b1};

	// input bit that leads into this state
	localparam logic IN_BIT = DEST_STATE[1];

	viterbi_pkg::sym_t diff_0;
	viterbi_pkg::sym_t diff_1;
	viterbi_pkg::pm_t  cand_0;
	viterbi_pkg::pm_t  cand_1;

	// hamming distance to the expected branch symbols
	assign diff_0 = in_sym ^ viterbi_pkg::branch_symbol(PRED_0, IN_BIT);
	assign diff_1 = in_sym ^ viterbi_pkg::branch_symbol(PRED_1, IN_BIT);

	assign cand_0 = pm_p0 + viterbi_pkg::pm_t'(diff_0[1]) + viterbi_pkg::pm_t'(diff_0[0]);
	assign cand_1 = pm_p1 + viterbi_pkg::pm_t'(diff_1[1]) + viterbi_pkg::pm_t'(diff_1[0]);

	always_comb begin
		if (unreach_p0 && unreach_p1) begin
			// nothing reaches this state yet
			pm_out      = '0;
			unreach_out = 1'b1;
			dec_out     = 1'b0;
		end else if (unreach_p0) begin
			pm_out      = cand_1;
			unreach_out = 1'b0;
			dec_out     = 1'b1;
		end else if (unreach_p1) begin
			pm_out      = cand_0;
			unreach_out = 1'b0;
			dec_out     = 1'b0;
		end else if (cand_1 < cand_0) begin
			pm_out      = cand_1;
			unreach_out = 1'b0;
			dec_out     = 1'b1;
		end else begin
			// tie goes to p0
			pm_out      = cand_0;
			unreach_out = 1'b0;
			dec_out     = 1'b0;
		end
	end

endmodule

// ==== rtl/viterbi_pkg.sv ====
package viterbi_pkg;

	// rate 1/2, K = 3, generators 7 and 5 (octal)
	localparam int NUM_STATES = 4;
	localparam int NUM_STAGES = 8;

	localparam int SYM_W   = 2;
	localparam int PM_W    = 7;
	localparam int ID_W    = 3;
	localparam int STATE_W = 2;

	typedef logic [SYM_W-1:0]   sym_t;
	typedef logic [PM_W-1:0]    pm_t;
	typedef logic [ID_W-1:0]    id_t;

	// bit 1 newest input bit, bit 0 the older one
	typedef logic [STATE_W-1:0] state_t;

	// element k feeds column k
	typedef sym_t [NUM_STAGES-1:0] sym_block_t;

	// one metric per state
	typedef pm_t [NUM_STATES-1:0] pm_vec_t;

	// unreachable flags, or one column of decisions
	typedef logic [NUM_STATES-1:0] flag_vec_t;

	// row k holds the decisions of column k
	typedef flag_vec_t [NUM_STAGES-1:0] dec_matrix_t;

	// every block starts in state 0 at metric 0 with the rest unreachable
	localparam pm_vec_t   PM_INIT      = '0;
	localparam flag_vec_t UNREACH_INIT = 4'b1110;

	// expected channel symbol for leaving prev_state with in_bit
	function automatic sym_t branch_symbol(
		input state_t prev_state,
		input logic   in_bit
	);
		sym_t sym;
		// generator 7 taps input and both state bits
		sym[1] = in_bit ^ prev_state[1] ^ prev_state[0];
		// generator 5 skips the middle tap
		sym[0] = in_bit ^ prev_state[0];
		return sym;
	endfunction

endpackage

// ==== sim/acs_matrix_asserts.sv ====
`timescale 1ns/100ps

module acs_matrix_asserts (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     in_ready,
	input logic                     out_valid,
	input logic                     out_ready,
	input viterbi_pkg::id_t         out_id,
	input viterbi_pkg::pm_vec_t     out_pm,
	input viterbi_pkg::dec_matrix_t out_dec
);

	a_reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else $error("out_valid high after a reset cycle");

	// stalled output must not change
	a_hold_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_id) && $stable(out_pm)
		&& $stable(out_dec))
		else $error("output changed while stalled");

	a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
		in_ready == (!out_valid || out_ready))
		else $error("in_ready does not follow the stall rule");

endmodule

bind acs_matrix acs_matrix_asserts u_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_id    (out_id),
	.out_pm    (out_pm),
	.out_dec   (out_dec)
);

// ==== sim/tb_acs_matrix.sv ====
`timescale 1ns/100ps

module tb_acs_matrix;

	logic                     clk = 1'b0;
	logic                     rst_n;
	logic                     in_valid;
	logic                     in_ready;
	viterbi_pkg::id_t         in_id;
	viterbi_pkg::sym_block_t  in_syms;
	logic                     out_valid;
	logic                     out_ready;
	viterbi_pkg::id_t         out_id;
	viterbi_pkg::pm_vec_t     out_pm;
	viterbi_pkg::dec_matrix_t out_dec;

	// stimulus table, one entry per test
	string            row_name [$];
	logic [7:0]       row_msg  [$];
	logic [15:0]      row_mask [$];
	viterbi_pkg::id_t row_id   [$];

	// expected results in send order
	string                    exp_name     [$];
	viterbi_pkg::id_t         exp_id       [$];
	viterbi_pkg::pm_vec_t     exp_pm       [$];
	viterbi_pkg::dec_matrix_t exp_dec      [$];
	bit                       exp_timed    [$];
	int                       accept_cycle [$];

	int          cycle = 0;
	int          cycle_limit = 0;
	int          num_blocks = 0;
	int          blocks_out = 0;
	int          pass_count = 0;
	int          fail_count = 0;
	int          other_errors = 0;
	int          blk_errors;
	string       cur_name;
	int          cur_accept;
	bit          cur_timed;
	logic        stall_mode = 1'b0;
	logic        gap_bit = 1'b0;
	logic [31:0] rnd_state = 32'd5;

	acs_matrix DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_id     (in_id),
		.in_syms   (in_syms),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_id    (out_id),
		.out_pm    (out_pm),
		.out_dec   (out_dec)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// encoder output for generators 7 and 5
	function automatic viterbi_pkg::sym_t code_pair(input logic [1:0] state, input logic u);
		viterbi_pkg::sym_t pair;
		pair[1] = u ^ state[1] ^ state[0];
		pair[0] = u ^ state[0];
		return pair;
	endfunction

	function automatic int hamming(input viterbi_pkg::sym_t a, input viterbi_pkg::sym_t b);
		viterbi_pkg::sym_t d;
		d = a ^ b;
		return int'(d[1]) + int'(d[0]);
	endfunction

	function automatic viterbi_pkg::sym_block_t encode_msg(input logic [7:0] msg,
		input logic [15:0] mask);
		viterbi_pkg::sym_block_t blk;
		logic [1:0] state;
		state = 2'b00;
		for (int k = 0; k < viterbi_pkg::NUM_STAGES; k++) begin
			blk[k] = code_pair(state, msg[k]) ^ mask[2*k +: 2];
			state  = {msg[k], state[1]};
		end
		return blk;
	endfunction

	// reference trellis model of the decoder
	task automatic run_model(input viterbi_pkg::sym_block_t syms,
		output viterbi_pkg::pm_vec_t pm, output viterbi_pkg::dec_matrix_t dec);
		int metric [4];
		int next_metric [4];
		bit reach [4];
		bit next_reach [4];
		int p0, p1, c0, c1;
		metric = '{0, 0, 0, 0};
		reach  = '{1, 0, 0, 0};
		dec    = '0;
		for (int k = 0; k < viterbi_pkg::NUM_STAGES; k++) begin
			for (int s = 0; s < 4; s++) begin
				p0 = 2 * (s % 2);
				p1 = p0 + 1;
				c0 = metric[p0] + hamming(syms[k], code_pair(2'(p0), 1'(s / 2)));
				c1 = metric[p1] + hamming(syms[k], code_pair(2'(p1), 1'(s / 2)));
				next_reach[s] = reach[p0] || reach[p1];
				if (!reach[p0] && !reach[p1]) begin
					next_metric[s] = 0;
				end else if (!reach[p0] || (reach[p1] && c1 < c0)) begin
					next_metric[s] = c1;
					dec[k][s] = 1'b1;
				end else begin
					next_metric[s] = c0;
				end
			end
			metric = next_metric;
			reach  = next_reach;
		end
		for (int s = 0; s < 4; s++) begin
			pm[s] = viterbi_pkg::pm_t'(metric[s]);
		end
	endtask

	task automatic add_row(input string name, input logic [7:0] msg, input logic [15:0] mask,
		input viterbi_pkg::id_t id);
		row_name.push_back(name);
		row_msg.push_back(msg);
		row_mask.push_back(mask);
		row_id.push_back(id);
	endtask

	task automatic check_id(input string name, input viterbi_pkg::id_t exp_val,
		input viterbi_pkg::id_t act_val);
		if (act_val !== exp_val) begin
			$display("Mismatch %s id: expected %0d, actual %0d", name, exp_val, act_val);
			blk_errors++;
		end
	endtask

	task automatic check_pm(input string name, input viterbi_pkg::pm_vec_t exp_val,
		input viterbi_pkg::pm_vec_t act_val);
		if (act_val !== exp_val) begin
			$display("Mismatch %s metrics: expected %h, actual %h", name, exp_val, act_val);
			blk_errors++;
		end
	endtask

	task automatic check_dec(input string name, input viterbi_pkg::dec_matrix_t exp_val,
		input viterbi_pkg::dec_matrix_t act_val);
		if (act_val !== exp_val) begin
			$display("Mismatch %s decisions: expected %h, actual %h", name, exp_val, act_val);
			blk_errors++;
		end
	endtask

	// holds valid and data until the DUT takes the block
	task automatic send_block(input int row, input bit no_gaps);
		if (!no_gaps) begin
			while (gap_bit) begin
				in_valid <= 1'b0;
				@(posedge clk);
			end
		end
		in_valid <= 1'b1;
		in_id    <= row_id[row];
		in_syms  <= encode_msg(row_msg[row], row_mask[row]);
		@(posedge clk);
		while (!in_ready) begin
			@(posedge clk);
		end
		accept_cycle.push_back(cycle);
	endtask

	always @(posedge clk) begin
		rnd_state = lcg_next(rnd_state);
		if (stall_mode) begin
			out_ready <= (rnd_state[25:24] != 2'b00);
			gap_bit   <= rnd_state[27];
		end else begin
			out_ready <= 1'b1;
			gap_bit   <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			if (accept_cycle.size() == 0) begin
				$display("Output block with id %0d appeared while none was sent", out_id);
				other_errors++;
			end else begin
				blk_errors = 0;
				cur_name   = exp_name.pop_front();
				cur_timed  = exp_timed.pop_front();
				cur_accept = accept_cycle.pop_front();
				check_id(cur_name, exp_id.pop_front(), out_id);
				check_pm(cur_name, exp_pm.pop_front(), out_pm);
				check_dec(cur_name, exp_dec.pop_front(), out_dec);
				if (cur_timed && cycle - cur_accept != viterbi_pkg::NUM_STAGES) begin
					$display("%s left %0d cycles after acceptance instead of %0d", cur_name,
						cycle - cur_accept, viterbi_pkg::NUM_STAGES);
					blk_errors++;
				end
				if (blk_errors == 0) begin
					pass_count++;
					$display("%-16s id %0d ok", cur_name, out_id);
				end else begin
					fail_count++;
					$display("%-16s id %0d FAILED", cur_name, out_id);
				end
			end
			blocks_out <= blocks_out + 1;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("Timeout after %0d cycles, outputs stopped arriving (%0d of %0d blocks)",
				cycle, blocks_out, num_blocks);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		viterbi_pkg::pm_vec_t     pm_tmp;
		viterbi_pkg::dec_matrix_t dec_tmp;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_id     = '0;
		in_syms   = '0;
		out_ready = 1'b1;

		add_row("clean_zeros",   8'h00, 16'h0000, 3'd0);
		add_row("clean_ones",    8'hff, 16'h0000, 3'd1);
		add_row("clean_alt",     8'h55, 16'h0000, 3'd2);
		add_row("clean_mix",     8'hb3, 16'h0000, 3'd3);
		add_row("flip_first",    8'ha6, 16'h0001, 3'd4);
		add_row("flip_mid",      8'h3c, 16'h0100, 3'd5);
		add_row("two_flips",     8'h71, 16'h0810, 3'd6);
		add_row("same_symbol",   8'hc9, 16'h0030, 3'd7);
		add_row("burst_tail",    8'h5e, 16'hc000, 3'd0);
		add_row("tie_at_start",  8'h00, 16'h0003, 3'd1);

		// two rounds, the second one with stalls and gaps
		for (int round = 0; round < 2; round++) begin
			for (int r = 0; r < row_name.size(); r++) begin
				run_model(encode_msg(row_msg[r], row_mask[r]), pm_tmp, dec_tmp);
				exp_name.push_back(row_name[r]);
				exp_id.push_back(row_id[r]);
				exp_pm.push_back(pm_tmp);
				exp_dec.push_back(dec_tmp);
				exp_timed.push_back(round == 0);
			end
		end
		num_blocks  = exp_name.size();
		cycle_limit = num_blocks * (viterbi_pkg::NUM_STAGES + 16) + 50;

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
			$display("DUT is not idle after reset (out_valid %b, in_ready %b)",
				out_valid, in_ready);
			other_errors++;
		end

		for (int r = 0; r < row_name.size(); r++) begin
			send_block(r, 1'b1);
		end
		in_valid <= 1'b0;
		while (blocks_out < row_name.size()) begin
			@(posedge clk);
		end

		stall_mode <= 1'b1;
		for (int r = 0; r < row_name.size(); r++) begin
			send_block(r, 1'b0);
		end
		in_valid <= 1'b0;
		while (blocks_out < num_blocks) begin
			@(posedge clk);
		end

		$display("blocks passed %0d, failed %0d, other errors %0d",
			pass_count, fail_count, other_errors);
		if (fail_count == 0 && other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
